// File: rtl/board_bus_pkg.sv
package board_bus_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // program ram depth in words
    localparam int ram_words = 256;
    localparam int ram_addr_w = $clog2(ram_words);

    // high address byte selects the page
    localparam logic [7:0] ram_page = 8'h00;
    localparam logic [7:0] reg_page = 8'h0f;

    // register offsets on the register page
    localparam logic [7:0] led_offset = 8'h00;
    localparam logic [7:0] duration_offset = 8'h0c;
    localparam logic [7:0] period_offset = 8'h10;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [strb_w-1:0] strb_t;

    // response of a completed transfer
    typedef struct packed {
        data_t rdata;
        logic err;
    } resp_t;

endpackage

// File: rtl/apb_if.sv
interface apb_if;

    logic psel;
    logic penable;
    logic pwrite;
    board_bus_pkg::addr_t paddr;
    board_bus_pkg::data_t pwdata;
    board_bus_pkg::strb_t pstrb;
    board_bus_pkg::data_t prdata;
    logic pready;
    logic pslverr;

    modport requester (
        output psel, penable, pwrite, paddr, pwdata, pstrb,
        input prdata, pready, pslverr
    );

    modport completer (
        input psel, penable, pwrite, paddr, pwdata, pstrb,
        output prdata, pready, pslverr
    );

endinterface

// File: rtl/bus_arbiter.sv
module bus_arbiter (
    input logic clock,
    input logic rst_n,

    input logic a_psel,
    input logic a_penable,
    input logic a_pwrite,
    input board_bus_pkg::addr_t a_paddr,
    input board_bus_pkg::data_t a_pwdata,
    input board_bus_pkg::strb_t a_pstrb,
    output board_bus_pkg::data_t a_prdata,
    output logic a_pready,
    output logic a_pslverr,

    input logic b_psel,
    input logic b_penable,
    input logic b_pwrite,
    input board_bus_pkg::addr_t b_paddr,
    input board_bus_pkg::data_t b_pwdata,
    input board_bus_pkg::strb_t b_pstrb,
    output board_bus_pkg::data_t b_prdata,
    output logic b_pready,
    output logic b_pslverr,

    apb_if.requester bus
);

    logic [1:0] grant_q;
    logic last_b_q;
    logic phase_q;

    logic pick_b;
    logic gnt_a;
    logic gnt_b;
    logic complete;

    // b wins a tie only if a won last time
    assign pick_b = b_psel & (~a_psel | ~last_b_q);

    // fresh grant while idle, held grant during the access phase
    assign gnt_a = phase_q ? grant_q[0] : (a_psel & ~pick_b);
    assign gnt_b = phase_q ? grant_q[1] : pick_b;

    assign complete = phase_q & bus.pready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            grant_q <= 2'b00;
            last_b_q <= 1'b0;
            phase_q <= 1'b0;
        end else if (complete) begin
            grant_q <= 2'b00;
            last_b_q <= grant_q[1];
            phase_q <= 1'b0;
        end else if (!phase_q && (gnt_a || gnt_b)) begin
            grant_q <= {gnt_b, gnt_a};
            phase_q <= 1'b1;
        end
    end

    // downstream mux, setup in the grant cycle
    assign bus.psel = gnt_a | gnt_b;
    assign bus.penable = phase_q & (gnt_b ? b_penable : a_penable);
    assign bus.pwrite = gnt_b ? b_pwrite : a_pwrite;
    assign bus.paddr = gnt_b ? b_paddr : a_paddr;
    assign bus.pwdata = gnt_b ? b_pwdata : a_pwdata;
    assign bus.pstrb = gnt_b ? b_pstrb : a_pstrb;

    // response only to the owner
    assign a_pready = gnt_a & complete;
    assign a_pslverr = gnt_a & complete & bus.pslverr;
    assign a_prdata = gnt_a ? bus.prdata : '0;

    assign b_pready = gnt_b & complete;
    assign b_pslverr = gnt_b & complete & bus.pslverr;
    assign b_prdata = gnt_b ? bus.prdata : '0;

endmodule

// File: rtl/addr_decoder.sv
module addr_decoder (
    apb_if.completer bus,
    apb_if.requester ram,
    apb_if.requester regs
);

    logic [7:0] high_byte;
    logic ram_hit;
    logic reg_hit;
    board_bus_pkg::resp_t resp;

    assign high_byte = bus.paddr[31:24];
    assign ram_hit = (high_byte == board_bus_pkg::ram_page);
    assign reg_hit = (high_byte == board_bus_pkg::reg_page);

    assign ram.psel = bus.psel & ram_hit;
    assign ram.penable = bus.penable;
    assign ram.pwrite = bus.pwrite;
    assign ram.paddr = bus.paddr;
    assign ram.pwdata = bus.pwdata;
    assign ram.pstrb = bus.pstrb;

    assign regs.psel = bus.psel & reg_hit;
    assign regs.penable = bus.penable;
    assign regs.pwrite = bus.pwrite;
    assign regs.paddr = bus.paddr;
    assign regs.pwdata = bus.pwdata;
    assign regs.pstrb = bus.pstrb;

    always_comb begin
        if (ram_hit) begin
            resp.rdata = ram.prdata;
            resp.err = ram.pslverr;
            bus.pready = ram.pready;
        end else if (reg_hit) begin
            resp.rdata = regs.prdata;
            resp.err = regs.pslverr;
            bus.pready = regs.pready;
        end else begin
            // unmapped, answer here with zero data
            resp.rdata = '0;
            resp.err = bus.psel & bus.penable;
            bus.pready = bus.psel & bus.penable;
        end
    end

    assign bus.prdata = resp.rdata;
    assign bus.pslverr = resp.err;

endmodule

// File: rtl/program_ram.sv
module program_ram (
    input logic clock,
    input logic rst_n,
    apb_if.completer bus
);

    localparam int idx_w = board_bus_pkg::ram_addr_w;

    board_bus_pkg::data_t mem [board_bus_pkg::ram_words];
    board_bus_pkg::data_t rdata_q;
    logic ready_q;
    logic [idx_w-1:0] idx;
    logic setup;
    logic access;

    // word index from byte address
    assign idx = bus.paddr[idx_w+1:2];
    assign setup = bus.psel & ~bus.penable;
    assign access = bus.psel & bus.penable;

    always_ff @(posedge clock) begin
        if (access && bus.pwrite) begin
            for (int i = 0; i < board_bus_pkg::strb_w; i++) begin
                if (bus.pstrb[i]) begin
                    mem[idx][i*8 +: 8] <= bus.pwdata[i*8 +: 8];
                end
            end
        end
        if (setup) begin
            rdata_q <= mem[idx];
        end
    end

    // zero wait states, ready follows every setup
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= setup;
        end
    end

    assign bus.prdata = rdata_q;
    assign bus.pready = ready_q & access;
    assign bus.pslverr = 1'b0;

endmodule

// File: rtl/tone_regs.sv
module tone_regs (
    input logic clock,
    input logic rst_n,
    apb_if.completer bus,
    output logic buzzer,
    output logic led,
    output logic tone_active
);

    board_bus_pkg::data_t led_q;
    board_bus_pkg::data_t period_q;
    board_bus_pkg::data_t duration_q;
    board_bus_pkg::data_t per_cnt_q;
    logic buzzer_q;

    logic [7:0] offset;
    logic access;
    logic known;
    logic wr;
    logic start;
    board_bus_pkg::data_t step_cnt;
    logic wrap;

    assign offset = bus.paddr[7:0];
    assign access = bus.psel & bus.penable;
    assign known = (offset == board_bus_pkg::led_offset) ||
                   (offset == board_bus_pkg::duration_offset) ||
                   (offset == board_bus_pkg::period_offset);
    assign wr = access & bus.pwrite & known;
    assign start = wr & (offset == board_bus_pkg::duration_offset);

    // the write edge counts as the first step of the period
    assign step_cnt = (start ? '0 : per_cnt_q) + 1'b1;
    assign wrap = (step_cnt == period_q);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            led_q <= '0;
            period_q <= '0;
            duration_q <= '0;
            per_cnt_q <= '0;
            buzzer_q <= 1'b0;
        end else begin
            if (wr && offset == board_bus_pkg::led_offset) begin
                led_q <= bus.pwdata;
            end
            if (wr && offset == board_bus_pkg::period_offset) begin
                period_q <= bus.pwdata;
            end
            if (start) begin
                duration_q <= bus.pwdata;
                per_cnt_q <= wrap ? '0 : step_cnt;
                buzzer_q <= wrap;
            end else if (duration_q != '0) begin
                duration_q <= duration_q - 1'b1;
                per_cnt_q <= wrap ? '0 : step_cnt;
                if (wrap) begin
                    buzzer_q <= ~buzzer_q;
                end
            end else begin
                per_cnt_q <= '0;
                buzzer_q <= 1'b0;
            end
        end
    end

    assign tone_active = (duration_q != '0);
    // silent as soon as the countdown ends
    assign buzzer = buzzer_q & tone_active;
    assign led = led_q[0];

    always_comb begin
        case (offset)
            board_bus_pkg::led_offset: bus.prdata = led_q;
            board_bus_pkg::duration_offset: bus.prdata = duration_q;
            board_bus_pkg::period_offset: bus.prdata = period_q;
            default: bus.prdata = '0;
        endcase
    end

    assign bus.pready = access;
    assign bus.pslverr = access & ~known;

endmodule

// File: rtl/board_bus_top.sv
module board_bus_top (
    input logic clock,
    input logic rst_n,

    input logic a_psel,
    input logic a_penable,
    input logic a_pwrite,
    input board_bus_pkg::addr_t a_paddr,
    input board_bus_pkg::data_t a_pwdata,
    input board_bus_pkg::strb_t a_pstrb,
    output board_bus_pkg::data_t a_prdata,
    output logic a_pready,
    output logic a_pslverr,

    input logic b_psel,
    input logic b_penable,
    input logic b_pwrite,
    input board_bus_pkg::addr_t b_paddr,
    input board_bus_pkg::data_t b_pwdata,
    input board_bus_pkg::strb_t b_pstrb,
    output board_bus_pkg::data_t b_prdata,
    output logic b_pready,
    output logic b_pslverr,

    output logic buzzer,
    output logic led,
    output logic tone_active
);

    apb_if bus_apb ();
    apb_if ram_apb ();
    apb_if reg_apb ();

    // processor on a, loader or debug host on b
    bus_arbiter u_bus_arbiter (
        .clock(clock),
        .rst_n(rst_n),
        .a_psel(a_psel),
        .a_penable(a_penable),
        .a_pwrite(a_pwrite),
        .a_paddr(a_paddr),
        .a_pwdata(a_pwdata),
        .a_pstrb(a_pstrb),
        .a_prdata(a_prdata),
        .a_pready(a_pready),
        .a_pslverr(a_pslverr),
        .b_psel(b_psel),
        .b_penable(b_penable),
        .b_pwrite(b_pwrite),
        .b_paddr(b_paddr),
        .b_pwdata(b_pwdata),
        .b_pstrb(b_pstrb),
        .b_prdata(b_prdata),
        .b_pready(b_pready),
        .b_pslverr(b_pslverr),
        .bus(bus_apb.requester)
    );

    addr_decoder u_addr_decoder (
        .bus(bus_apb.completer),
        .ram(ram_apb.requester),
        .regs(reg_apb.requester)
    );

    program_ram u_program_ram (
        .clock(clock),
        .rst_n(rst_n),
        .bus(ram_apb.completer)
    );

    tone_regs u_tone_regs (
        .clock(clock),
        .rst_n(rst_n),
        .bus(reg_apb.completer),
        .buzzer(buzzer),
        .led(led),
        .tone_active(tone_active)
    );

endmodule

// File: bench/clock_gen.sv
module clock_gen (
    output logic clock,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period
    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // held low over the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

// File: bench/board_bus_asserts.sv
module board_bus_asserts (
    input logic clock,
    input logic rst_n,
    input logic psel,
    input logic penable,
    input logic [1:0] grant_q,
    input logic a_psel,
    input logic a_penable,
    input logic a_pready,
    input logic b_psel,
    input logic b_penable,
    input logic b_pready
);
    timeunit 1ns;
    timeprecision 1ps;

    int violations = 0;

    penable_needs_psel: assert property (
        @(posedge clock) disable iff (!rst_n) penable |-> psel
    ) else begin
        violations++;
        $error("downstream penable without psel");
    end

    one_grant: assert property (
        @(posedge clock) disable iff (!rst_n) !(grant_q[0] && grant_q[1])
    ) else begin
        violations++;
        $error("both ports granted at once");
    end

    // pready goes back only to the owner of the bus, in its access phase
    ready_a_owned: assert property (
        @(posedge clock) disable iff (!rst_n) a_pready |-> (grant_q[0] && a_psel && a_penable)
    ) else begin
        violations++;
        $error("pready on port a without a grant");
    end

    ready_b_owned: assert property (
        @(posedge clock) disable iff (!rst_n) b_pready |-> (grant_q[1] && b_psel && b_penable)
    ) else begin
        violations++;
        $error("pready on port b without a grant");
    end

endmodule

// File: bench/tb_board_bus.sv
module tb_board_bus;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic port_b;
        logic write;
        board_bus_pkg::addr_t addr;
        board_bus_pkg::data_t data;
        board_bus_pkg::strb_t strb;
        board_bus_pkg::data_t exp_data;
        logic exp_err;
    } entry_t;

    logic clock;
    logic rst_n;
    logic a_psel = 1'b0;
    logic a_penable = 1'b0;
    logic a_pwrite = 1'b0;
    board_bus_pkg::addr_t a_paddr = '0;
    board_bus_pkg::data_t a_pwdata = '0;
    board_bus_pkg::strb_t a_pstrb = '0;
    board_bus_pkg::data_t a_prdata;
    logic a_pready;
    logic a_pslverr;
    logic b_psel = 1'b0;
    logic b_penable = 1'b0;
    logic b_pwrite = 1'b0;
    board_bus_pkg::addr_t b_paddr = '0;
    board_bus_pkg::data_t b_pwdata = '0;
    board_bus_pkg::strb_t b_pstrb = '0;
    board_bus_pkg::data_t b_prdata;
    logic b_pready;
    logic b_pslverr;
    logic buzzer;
    logic led;
    logic tone_active;

    board_bus_pkg::data_t model [board_bus_pkg::ram_words];
    logic [7:0] used_idx [$];
    entry_t stim [$];
    logic [31:0] lcg_state = 32'hbcb1;
    // port of the last completed transfer
    logic last_b = 1'b0;

    clock_gen u_clock_gen (
        .clock(clock),
        .rst_n(rst_n)
    );

    board_bus_top u_board_bus_top (.*);

    bind bus_arbiter board_bus_asserts u_arbiter_asserts (
        .clock(clock),
        .rst_n(rst_n),
        .psel(bus.psel),
        .penable(bus.penable),
        .grant_q(grant_q),
        .a_psel(a_psel),
        .a_penable(a_penable),
        .a_pready(a_pready),
        .b_psel(b_psel),
        .b_penable(b_penable),
        .b_pready(b_pready)
    );

    // upper half of the state comes out in the low bits
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    function automatic board_bus_pkg::addr_t ram_addr(input logic [7:0] idx);
        return {board_bus_pkg::ram_page, 14'd0, idx, 2'b00};
    endfunction

    function automatic board_bus_pkg::addr_t reg_addr(input logic [7:0] offset);
        return {board_bus_pkg::reg_page, 16'h0000, offset};
    endfunction

    function automatic board_bus_pkg::data_t apply_strobe(input board_bus_pkg::data_t old_word,
                                                          input board_bus_pkg::data_t new_word,
                                                          input board_bus_pkg::strb_t strb);
        board_bus_pkg::data_t w;
        w = old_word;
        for (int i = 0; i < board_bus_pkg::strb_w; i++) begin
            if (strb[i]) begin
                w[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return w;
    endfunction

    function automatic void add_entry(input logic port_b, input logic write,
                                      input board_bus_pkg::addr_t addr,
                                      input board_bus_pkg::data_t data,
                                      input board_bus_pkg::strb_t strb,
                                      input board_bus_pkg::data_t exp_data,
                                      input logic exp_err);
        stim.push_back('{port_b, write, addr, data, strb, exp_data, exp_err});
    endfunction

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic fail_check(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        abort_run();
    endtask

    task automatic check_resp(input board_bus_pkg::resp_t got, input board_bus_pkg::resp_t exp,
                              input logic with_data, input string what);
        if (got.err !== exp.err || (with_data && got.rdata !== exp.rdata)) begin
            fail_check($sformatf("%s: data %h err %b, expected data %h err %b",
                                 what, got.rdata, got.err, exp.rdata, exp.err));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_check($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            fail_check($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic apb_transfer(input logic port_b, input logic write,
                                input board_bus_pkg::addr_t addr,
                                input board_bus_pkg::data_t data,
                                input board_bus_pkg::strb_t strb,
                                output board_bus_pkg::resp_t resp, output int cycles);
        logic got;
        got = 1'b0;
        cycles = 0;
        resp = '0;
        @(posedge clock);
        if (port_b) begin
            b_psel <= 1'b1;
            b_penable <= 1'b0;
            b_pwrite <= write;
            b_paddr <= addr;
            b_pwdata <= data;
            b_pstrb <= strb;
        end else begin
            a_psel <= 1'b1;
            a_penable <= 1'b0;
            a_pwrite <= write;
            a_paddr <= addr;
            a_pwdata <= data;
            a_pstrb <= strb;
        end
        // penable after the setup cycle, both dropped once pready is seen
        while (!got) begin
            @(negedge clock);
            cycles++;
            if (port_b ? b_pready : a_pready) begin
                resp.rdata = port_b ? b_prdata : a_prdata;
                resp.err = port_b ? b_pslverr : a_pslverr;
                got = 1'b1;
            end else if (cycles >= 40) begin
                stop_on_timeout(port_b ? "pready on port b" : "pready on port a");
            end
            @(posedge clock);
            if (port_b) begin
                b_psel <= ~got;
                b_penable <= ~got;
            end else begin
                a_psel <= ~got;
                a_penable <= ~got;
            end
        end
        last_b = port_b;
    endtask

    task automatic build_stimulus();
        logic [7:0] idx;
        board_bus_pkg::strb_t strb;
        board_bus_pkg::data_t word;
        for (int i = 0; i < 8; i++) begin
            idx = 8'(next_rand());
            word = next_rand();
            used_idx.push_back(idx);
            model[idx] = word;
            add_entry(1'b0, 1'b1, ram_addr(idx), word, 4'hf, '0, 1'b0);
        end
        foreach (used_idx[i]) begin
            add_entry(1'b0, 1'b0, ram_addr(used_idx[i]), '0, 4'hf, model[used_idx[i]], 1'b0);
        end
        // partial strobes over words that already hold data
        for (int i = 0; i < 6; i++) begin
            idx = used_idx[i];
            strb = 4'(next_rand());
            if (strb == 4'h0 || strb == 4'hf) begin
                strb = 4'h9;
            end
            word = next_rand();
            model[idx] = apply_strobe(model[idx], word, strb);
            add_entry(1'b0, 1'b1, ram_addr(idx), word, strb, '0, 1'b0);
            add_entry(1'b0, 1'b0, ram_addr(idx), '0, 4'hf, model[idx], 1'b0);
        end
        // unmapped pages, then an unknown register offset
        add_entry(1'b0, 1'b0, 32'h2000_0010, '0, 4'hf, '0, 1'b1);
        add_entry(1'b1, 1'b1, 32'h8000_0040, 32'hdead_beef, 4'hf, '0, 1'b1);
        add_entry(1'b0, 1'b0, reg_addr(8'h04), '0, 4'hf, '0, 1'b1);
        add_entry(1'b0, 1'b1, reg_addr(board_bus_pkg::led_offset), 32'ha5, 4'hf, '0, 1'b0);
        add_entry(1'b0, 1'b0, reg_addr(board_bus_pkg::led_offset), '0, 4'hf, 32'ha5, 1'b0);
    endtask

    task automatic check_tie(input logic write, input logic [7:0] idx_a, input logic [7:0] idx_b);
        board_bus_pkg::resp_t resp_a;
        board_bus_pkg::resp_t resp_b;
        board_bus_pkg::resp_t exp_a;
        board_bus_pkg::resp_t exp_b;
        board_bus_pkg::data_t data_a;
        board_bus_pkg::data_t data_b;
        int cyc_a;
        int cyc_b;
        logic b_first;
        data_a = next_rand();
        data_b = next_rand();
        // the port that did not win last goes first
        b_first = ~last_b;
        exp_a = {model[idx_a], 1'b0};
        exp_b = {model[idx_b], 1'b0};
        fork
            apb_transfer(1'b0, write, ram_addr(idx_a), data_a, 4'hf, resp_a, cyc_a);
            apb_transfer(1'b1, write, ram_addr(idx_b), data_b, 4'hf, resp_b, cyc_b);
        join
        check_count(b_first ? cyc_b : cyc_a, 2, "cycles of the tie winner");
        check_count(b_first ? cyc_a : cyc_b, 4, "cycles of the tie loser");
        check_resp(resp_a, exp_a, ~write, "port a in a tie");
        check_resp(resp_b, exp_b, ~write, "port b in a tie");
        if (write) begin
            model[idx_a] = data_a;
            model[idx_b] = data_b;
        end
    endtask

    task automatic check_tone(input board_bus_pkg::data_t period,
                              input board_bus_pkg::data_t duration);
        board_bus_pkg::resp_t resp;
        board_bus_pkg::resp_t ok;
        int cycles;
        int active;
        int toggles;
        logic prev;
        logic done;
        ok = '0;
        apb_transfer(1'b0, 1'b1, reg_addr(board_bus_pkg::period_offset), period, 4'hf,
                     resp, cycles);
        check_resp(resp, ok, 1'b0, "period write");
        @(negedge clock);
        check_bit(tone_active, 1'b0, "tone_active before the duration write");
        apb_transfer(1'b0, 1'b1, reg_addr(board_bus_pkg::duration_offset), duration, 4'hf,
                     resp, cycles);
        check_resp(resp, ok, 1'b0, "duration write");
        active = 0;
        toggles = 0;
        prev = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge clock);
            if (tone_active !== 1'b1) begin
                done = 1'b1;
            end else begin
                active++;
                if (buzzer !== prev) begin
                    toggles++;
                end
                prev = buzzer;
                if (active > int'(duration) + 8) begin
                    stop_on_timeout("the end of the tone");
                end
            end
        end
        check_count(active, int'(duration), "tone length in cycles");
        check_count(toggles, int'(duration / period), "buzzer toggles");
        check_bit(buzzer, 1'b0, "buzzer after the tone");
    endtask

    initial begin
        board_bus_pkg::resp_t got;
        board_bus_pkg::resp_t exp;
        board_bus_pkg::data_t dur;
        int cycles;
        int n;
        logic [7:0] idx;
        build_stimulus();
        n = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clock);
            n++;
            if (n > 10) begin
                stop_on_timeout("reset release");
            end
        end
        @(negedge clock);
        check_bit(a_pready, 1'b0, "a_pready after reset");
        check_bit(b_pready, 1'b0, "b_pready after reset");
        check_bit(buzzer, 1'b0, "buzzer after reset");
        check_bit(led, 1'b0, "led after reset");

        foreach (stim[i]) begin
            apb_transfer(stim[i].port_b, stim[i].write, stim[i].addr, stim[i].data,
                         stim[i].strb, got, cycles);
            exp.rdata = stim[i].exp_data;
            exp.err = stim[i].exp_err;
            check_resp(got, exp, ~stim[i].write, $sformatf("table entry %0d", i));
        end
        @(negedge clock);
        check_bit(led, 1'b1, "led pin after the led write");

        // simultaneous requests, a write round then a crossed read round
        idx = 8'(next_rand());
        check_tie(1'b1, idx, idx ^ 8'h80);
        check_tie(1'b0, idx ^ 8'h80, idx);

        check_tone(32'd3, 32'd10);
        check_tone(32'd1, 32'd5);
        dur = 32'd12 + (next_rand() & 32'h0000_000f);
        check_tone(32'd4, dur);

        n = u_board_bus_top.u_bus_arbiter.u_arbiter_asserts.violations;
        if (n == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("%0d protocol assertion failures on the arbiter", n);
            abort_run();
        end
    end

endmodule

// File: project.f
rtl/board_bus_pkg.sv
rtl/apb_if.sv
rtl/bus_arbiter.sv
rtl/addr_decoder.sv
rtl/program_ram.sv
rtl/tone_regs.sv
rtl/board_bus_top.sv
bench/clock_gen.sv
bench/board_bus_asserts.sv
bench/tb_board_bus.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the board bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board_bus --Mdir obj_dir -o sim_board_bus -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_board_bus +verilator+error+limit+100 > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

echo "simulation finished without failures"
exit 0
